// File: rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // System clock in Hz
    localparam int unsigned CLK_FREQ = 25_000_000;

    // Serial line rate
    localparam int unsigned BAUD = 115_200;

    // Line samples taken in each bit period
    localparam logic [1:0] SAMPLES_PER_BIT = 2'd3;

    // Clock cycles between two sample ticks, rounded down
    localparam int unsigned TICKS_PER_SAMPLE = CLK_FREQ / (BAUD * SAMPLES_PER_BIT);

    // Tick counter width
    localparam int TICK_CNT_W = $clog2(TICKS_PER_SAMPLE);

    // Data bits in one character, also the byte width of the design
    localparam logic [3:0] DATA_BITS = 4'd8;

endpackage

`default_nettype wire

// File: rtl/frame_pkg.sv
`default_nettype none

package frame_pkg;

    // Frame delimiters on the serial link
    localparam logic [uart_pkg::DATA_BITS-1:0] START_MARKER = 8'hFE;
    localparam logic [uart_pkg::DATA_BITS-1:0] END_MARKER   = 8'hFF;

    // Four A operands followed by four B operands
    localparam logic [3:0] NUM_OPERANDS = 4'd8;

    // Width of an operand slot index
    localparam int OPERAND_IDX_W = 3;

    // Operand word seen either as one value or as its two bytes
    typedef union packed {
        logic [2*uart_pkg::DATA_BITS-1:0] word;
        struct packed {
            logic [uart_pkg::DATA_BITS-1:0] hi;
            logic [uart_pkg::DATA_BITS-1:0] lo;
        } octets;
    } operand_word_t;

    // Parser states
    typedef enum logic [1:0] {
        PS_IDLE,
        PS_HIGH,
        PS_LOW,
        PS_WAIT_END
    } parser_state_t;

endpackage

`default_nettype wire

// File: rtl/byte_stream_if.sv
`timescale 1ns/1ns
`default_nettype none

interface byte_stream_if;
    import uart_pkg::*;

    // Byte handshake, a transfer happens when valid and ready are both high
    logic                 valid;
    logic                 ready;
    logic [DATA_BITS-1:0] data;
    // Single cycle framing error pulse, never together with valid
    logic                 err;

    modport source (output valid, output data, output err, input ready);

    modport sink (input valid, input data, input err, output ready);

endinterface

`default_nettype wire

// File: rtl/sample_tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

module sample_tick_gen (
    input  logic clk,
    input  logic reset,
    input  logic restart_i,
    output logic tick_o
);
    import uart_pkg::*;

    logic [TICK_CNT_W-1:0] cnt_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cnt_q  <= TICK_CNT_W'(TICKS_PER_SAMPLE - 1);
            tick_o <= 1'b0;
        end else if (restart_i) begin
            // Half a sample period so ticks land mid sample
            cnt_q  <= TICK_CNT_W'(TICKS_PER_SAMPLE / 2 - 1);
            tick_o <= 1'b0;
        end else if (cnt_q == '0) begin
            // Expiry gives one tick, then a full period again
            cnt_q  <= TICK_CNT_W'(TICKS_PER_SAMPLE - 1);
            tick_o <= 1'b1;
        end else begin
            cnt_q  <= cnt_q - 1'b1;
            tick_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic          clk,
    input  logic          reset,
    input  logic          rxd_i,
    byte_stream_if.source stream
);
    import uart_pkg::*;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_FULL
    } rx_state_t;

    rx_state_t            state_q;
    logic                 rx_meta_q;
    logic                 rx_sync_q;
    logic [1:0]           hist_q;
    logic [1:0]           smp_cnt_q;
    logic [3:0]           bit_cnt_q;
    logic [DATA_BITS-1:0] shift_q;
    logic                 err_q;
    logic                 restart;
    logic                 tick;
    logic                 bit_done;
    logic                 bit_val;

    // Two flop synchronizer, line idles high
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= rxd_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    // Falling line in idle marks a start edge
    assign restart = (state_q == RX_IDLE) && !rx_sync_q;

    sample_tick_gen u_tick_gen (
        .clk       (clk),
        .reset     (reset),
        .restart_i (restart),
        .tick_o    (tick)
    );

    // Earlier two samples of the current bit
    always_ff @(posedge clk) begin
        if (tick) begin
            hist_q <= {hist_q[0], rx_sync_q};
        end
    end

    // Third sample of a bit decides it by majority
    assign bit_done = tick && (smp_cnt_q == SAMPLES_PER_BIT - 2'd1);
    assign bit_val  = (hist_q[1] & hist_q[0]) | (hist_q[1] & rx_sync_q) |
                      (hist_q[0] & rx_sync_q);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q   <= RX_IDLE;
            smp_cnt_q <= 2'd0;
            bit_cnt_q <= 4'd0;
            err_q     <= 1'b0;
        end else begin
            err_q <= 1'b0;
            if (restart) begin
                smp_cnt_q <= 2'd0;
            end else if (tick) begin
                smp_cnt_q <= bit_done ? 2'd0 : smp_cnt_q + 2'd1;
            end
            case (state_q)
                RX_IDLE: begin
                    if (!rx_sync_q) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // High majority means a glitch, not a start bit
                    if (bit_done) begin
                        state_q   <= bit_val ? RX_IDLE : RX_DATA;
                        bit_cnt_q <= 4'd0;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        bit_cnt_q <= bit_cnt_q + 4'd1;
                        if (bit_cnt_q == DATA_BITS - 4'd1) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_done) begin
                        // Low stop bit drops the byte
                        state_q <= bit_val ? RX_FULL : RX_IDLE;
                        err_q   <= !bit_val;
                    end
                end
                RX_FULL: begin
                    // Byte held until the sink takes it
                    if (stream.ready) begin
                        state_q <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && bit_done) begin
            shift_q <= {bit_val, shift_q[DATA_BITS-1:1]};
        end
    end

    assign stream.valid = (state_q == RX_FULL);
    assign stream.data  = shift_q;
    assign stream.err   = err_q;

endmodule

`default_nettype wire

// File: rtl/frame_parser.sv
`timescale 1ns/1ns
`default_nettype none

module frame_parser (
    input  logic                             clk,
    input  logic                             reset,
    byte_stream_if.sink                      stream,
    output logic                             wr_en_o,
    output logic [frame_pkg::OPERAND_IDX_W-1:0] wr_idx_o,
    output logic                             wr_hi_o,
    output logic [uart_pkg::DATA_BITS-1:0]   wr_byte_o,
    output logic                             frame_valid_o
);
    import uart_pkg::*;
    import frame_pkg::*;

    parser_state_t            state_q;
    logic [DATA_BITS-1:0]     hold_q;
    logic                     hold_full_q;
    logic                     err_q;
    logic [OPERAND_IDX_W-1:0] idx_q;
    logic                     take;

    // One byte holding register, ready while it is empty
    assign stream.ready = !hold_full_q;
    assign take         = stream.valid && !hold_full_q;

    always_ff @(posedge clk) begin
        if (take) begin
            hold_q <= stream.data;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q       <= PS_IDLE;
            hold_full_q   <= 1'b0;
            err_q         <= 1'b0;
            idx_q         <= '0;
            frame_valid_o <= 1'b0;
        end else begin
            err_q <= stream.err;
            // Held byte is consumed one cycle after its transfer
            if (take) begin
                hold_full_q <= 1'b1;
            end else if (hold_full_q) begin
                hold_full_q <= 1'b0;
            end
            if (err_q) begin
                // Framing error aborts the frame
                state_q       <= PS_IDLE;
                frame_valid_o <= 1'b0;
            end else if (hold_full_q) begin
                case (state_q)
                    PS_IDLE: begin
                        if (hold_q == START_MARKER) begin
                            frame_valid_o <= 1'b0;
                            idx_q         <= '0;
                            state_q       <= PS_HIGH;
                        end
                    end
                    PS_HIGH: state_q <= PS_LOW;
                    PS_LOW: begin
                        // Low byte completes the operand
                        if (idx_q == OPERAND_IDX_W'(NUM_OPERANDS - 4'd1)) begin
                            state_q <= PS_WAIT_END;
                        end else begin
                            idx_q   <= idx_q + 1'b1;
                            state_q <= PS_HIGH;
                        end
                    end
                    PS_WAIT_END: begin
                        // Anything but the end marker is skipped
                        if (hold_q == END_MARKER) begin
                            frame_valid_o <= 1'b1;
                            state_q       <= PS_IDLE;
                        end
                    end
                    default: state_q <= PS_IDLE;
                endcase
            end
        end
    end

    // Store write straight from the held byte
    assign wr_en_o   = hold_full_q && !err_q &&
                       (state_q == PS_HIGH || state_q == PS_LOW);
    assign wr_idx_o  = idx_q;
    assign wr_hi_o   = (state_q == PS_HIGH);
    assign wr_byte_o = hold_q;

endmodule

`default_nettype wire

// File: rtl/operand_store.sv
`timescale 1ns/1ns
`default_nettype none

module operand_store (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wr_en_i,
    input  logic [frame_pkg::OPERAND_IDX_W-1:0] wr_idx_i,
    input  logic                                wr_hi_i,
    input  logic [uart_pkg::DATA_BITS-1:0]      wr_byte_i,
    input  logic [frame_pkg::OPERAND_IDX_W-1:0] rd_idx_i,
    output logic [2*uart_pkg::DATA_BITS-1:0]    rd_word_o
);
    import frame_pkg::*;

    operand_word_t ops_q [NUM_OPERANDS];

    // Byte writes into the addressed operand
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < NUM_OPERANDS; i++) begin
                ops_q[i].word <= '0;
            end
        end else if (wr_en_i) begin
            if (wr_hi_i) begin
                ops_q[wr_idx_i].octets.hi <= wr_byte_i;
            end else begin
                ops_q[wr_idx_i].octets.lo <= wr_byte_i;
            end
        end
    end

    // Word wide read mux
    assign rd_word_o = ops_q[rd_idx_i].word;

endmodule

`default_nettype wire

// File: rtl/neural_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

module neural_rx_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                rxd_i,
    input  logic [frame_pkg::OPERAND_IDX_W-1:0] operand_sel_i,
    output logic [2*uart_pkg::DATA_BITS-1:0]    operand_o,
    output logic                                frame_valid_o
);
    import uart_pkg::*;
    import frame_pkg::*;

    // Store write port from the parser
    logic                     wr_en;
    logic [OPERAND_IDX_W-1:0] wr_idx;
    logic                     wr_hi;
    logic [DATA_BITS-1:0]     wr_byte;

    byte_stream_if rx_stream ();

    uart_rx u_uart_rx (
        .clk    (clk),
        .reset  (reset),
        .rxd_i  (rxd_i),
        .stream (rx_stream.source)
    );

    frame_parser u_frame_parser (
        .clk           (clk),
        .reset         (reset),
        .stream        (rx_stream.sink),
        .wr_en_o       (wr_en),
        .wr_idx_o      (wr_idx),
        .wr_hi_o       (wr_hi),
        .wr_byte_o     (wr_byte),
        .frame_valid_o (frame_valid_o)
    );

    operand_store u_operand_store (
        .clk       (clk),
        .reset     (reset),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_hi_i   (wr_hi),
        .wr_byte_i (wr_byte),
        .rd_idx_i  (operand_sel_i),
        .rd_word_o (operand_o)
    );

endmodule

`default_nettype wire

// File: verification/neural_rx_assert.sv
`timescale 1ns/1ns
`default_nettype none

module neural_rx_assert (
    input wire logic                           clk,
    input wire logic                           reset,
    input wire logic                           valid_i,
    input wire logic                           ready_i,
    input wire logic [uart_pkg::DATA_BITS-1:0] data_i,
    input wire logic                           err_i
);

    // A byte waiting for the sink keeps valid and data steady
    property p_valid_held;
        @(posedge clk) disable iff (!reset)
            (valid_i && !ready_i) |=> (valid_i && $stable(data_i));
    endproperty

    // Framing error pulse never overlaps a held byte
    property p_no_valid_with_err;
        @(posedge clk) disable iff (!reset)
            !(valid_i && err_i);
    endproperty

    // Nothing offered while in reset
    property p_no_valid_in_reset;
        @(posedge clk) !reset |-> !valid_i;
    endproperty

    a_valid_held: assert property (p_valid_held)
        else $error("valid or data changed before the byte was taken");

    a_no_valid_with_err: assert property (p_no_valid_with_err)
        else $error("valid and err high in the same cycle");

    a_no_valid_in_reset: assert property (p_no_valid_in_reset)
        else $error("valid high while reset is asserted");

endmodule

`default_nettype wire

// File: verification/tb_neural_rx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_neural_rx;
    import uart_pkg::*;
    import frame_pkg::*;

    localparam int NUM_ROWS    = 7;
    localparam int BIT_CYCLES  = TICKS_PER_SAMPLE * SAMPLES_PER_BIT;
    localparam int WAIT_LIMIT  = 64;
    localparam int DRIVE_DELAY = 2;

    logic        clk;
    logic        reset;
    logic        rxd;
    logic [2:0]  operand_sel;
    logic [15:0] operand;
    logic        frame_valid;

    // Frame table with one row per frame
    logic [15:0] row_ops [NUM_ROWS][8];
    int          row_junk [NUM_ROWS];
    // Byte position whose stop bit goes low
    // Position 0 is the start marker and -1 means none
    int          row_bad_pos [NUM_ROWS];
    bit          row_no_end [NUM_ROWS];
    bit          row_exp_fv [NUM_ROWS];

    // Reference of the parser rules and the operand store
    parser_state_t m_state;
    int            m_idx;
    logic [15:0]   m_ops [8];

    int checks;
    int errors;

    neural_rx_top UUT (
        .clk           (clk),
        .reset         (reset),
        .rxd_i         (rxd),
        .operand_sel_i (operand_sel),
        .operand_o     (operand),
        .frame_valid_o (frame_valid)
    );

    bind uart_rx neural_rx_assert u_stream_assert (
        .clk     (clk),
        .reset   (reset),
        .valid_i (stream.valid),
        .ready_i (stream.ready),
        .data_i  (stream.data),
        .err_i   (stream.err)
    );

    always #20 clk = ~clk;

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic set_row(input int r, input int junk, input int bad_pos,
                           input bit no_end, input bit exp_fv);
        row_junk[r]    = junk;
        row_bad_pos[r] = bad_pos;
        row_no_end[r]  = no_end;
        row_exp_fv[r]  = exp_fv;
    endtask

    // Words packed A0 first down to B3 last
    task automatic set_ops(input int r, input logic [127:0] words);
        for (int i = 0; i < 8; i++) begin
            row_ops[r][i] = words[127-16*i -: 16];
        end
    endtask

    task automatic set_random_ops(input int r);
        for (int i = 0; i < 8; i++) begin
            row_ops[r][i] = 16'($urandom);
        end
    endtask

    task automatic fill_table();
        // Clean frame with marker values as operand data
        set_row(0, 0, -1, 1'b0, 1'b1);
        set_ops(0, {16'hFEFF, 16'hFFFE, 16'h1234, 16'h00FF,
                    16'hFE00, 16'hA5C3, 16'h0001, 16'h8000});
        // Junk ahead of the start marker
        set_row(1, 3, -1, 1'b0, 1'b1);
        set_random_ops(1);
        // No end marker so the parser keeps waiting for one
        set_row(2, 0, -1, 1'b1, 1'b0);
        set_ops(2, {16'h1111, 16'h2222, 16'h3333, 16'h4444,
                    16'h5555, 16'h6666, 16'h7777, 16'h8888});
        // Skipped while waiting until its own end marker
        // No 0xFF in the data bytes
        set_row(3, 0, -1, 1'b0, 1'b1);
        set_ops(3, {16'h0A0B, 16'h0C0D, 16'h1E2F, 16'h3040,
                    16'h5060, 16'h7080, 16'h90A0, 16'hB0C0});
        // Bad stop bit on the high byte of operand 3
        // No marker values in the data
        set_row(4, 1, 7, 1'b0, 1'b0);
        set_ops(4, {16'h1357, 16'h9BDF, 16'h2468, 16'hACE0,
                    16'h0F1E, 16'h2D3C, 16'h4B5A, 16'h6978});
        set_row(5, 0, -1, 1'b0, 1'b1);
        set_random_ops(5);
        // Full overwrite with new values
        set_row(6, 2, -1, 1'b0, 1'b1);
        set_random_ops(6);
    endtask

    // Parser rules applied to one received byte
    task automatic model_byte(input logic [7:0] b, input bit bad);
        if (bad) begin
            m_state = PS_IDLE;
        end else begin
            case (m_state)
                PS_IDLE: begin
                    if (b == START_MARKER) begin
                        m_idx   = 0;
                        m_state = PS_HIGH;
                    end
                end
                PS_HIGH: begin
                    m_ops[m_idx][15:8] = b;
                    m_state = PS_LOW;
                end
                PS_LOW: begin
                    m_ops[m_idx][7:0] = b;
                    if (m_idx == 7) begin
                        m_state = PS_WAIT_END;
                    end else begin
                        m_idx   = m_idx + 1;
                        m_state = PS_HIGH;
                    end
                end
                default: begin
                    if (b == END_MARKER) begin
                        m_state = PS_IDLE;
                    end
                end
            endcase
        end
    endtask

    // One bit period on the line driven just after the clock edge
    task automatic drive_bit(input logic v);
        @(posedge clk);
        #DRIVE_DELAY rxd = v;
        repeat (BIT_CYCLES - 1) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b, input bit bad_stop);
        drive_bit(1'b0);
        for (int i = 0; i < DATA_BITS; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(!bad_stop);
        // Idle time so the start seen in a low stop bit turns out false
        if (bad_stop) begin
            drive_bit(1'b1);
            drive_bit(1'b1);
        end
        model_byte(b, bad_stop);
    endtask

    task automatic send_frame(input int r);
        logic [7:0] b;
        // Junk stays below 0xFE
        for (int j = 0; j < row_junk[r]; j++) begin
            b = 8'($urandom % 254);
            send_byte(b, 1'b0);
        end
        for (int k = 0; k < 18; k++) begin
            if (k == 0) begin
                b = START_MARKER;
            end else if (k == 17) begin
                b = END_MARKER;
            end else if (k % 2 == 1) begin
                b = row_ops[r][(k-1)/2][15:8];
            end else begin
                b = row_ops[r][(k-1)/2][7:0];
            end
            if (k < 17 || !row_no_end[r]) begin
                send_byte(b, (k == row_bad_pos[r]));
            end
        end
    endtask

    task automatic wait_frame_valid(input logic exp);
        int n;
        n = 0;
        @(negedge clk);
        while (frame_valid !== exp && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (frame_valid !== exp) begin
            errors++;
            $display("Timeout at %0t ns: frame_valid_o did not reach %0b", $time, exp);
        end
    endtask

    task automatic read_operands();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #DRIVE_DELAY operand_sel = 3'(i);
            @(negedge clk);
            compare_value($sformatf("operand_o[%0d]", i), operand, m_ops[i]);
        end
    endtask

    initial begin
        void'($urandom(32'h91bd));
        clk         = 1'b0;
        reset       = 1'b0;
        rxd         = 1'b1;
        operand_sel = 3'd0;
        checks      = 0;
        errors      = 0;
        m_state     = PS_IDLE;
        m_idx       = 0;
        for (int i = 0; i < 8; i++) begin
            m_ops[i] = 16'h0000;
        end
        fill_table();

        repeat (5) @(posedge clk);
        #DRIVE_DELAY reset = 1'b1;
        repeat (4) @(posedge clk);

        // Store and flag cleared by reset
        @(negedge clk);
        compare_value("frame_valid_o", {15'b0, frame_valid}, 16'h0000);
        read_operands();

        for (int r = 0; r < NUM_ROWS; r++) begin
            send_frame(r);
            wait_frame_valid(row_exp_fv[r]);
            read_operands();
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
rtl/uart_pkg.sv
rtl/frame_pkg.sv
rtl/byte_stream_if.sv
rtl/sample_tick_gen.sv
rtl/uart_rx.sv
rtl/frame_parser.sv
rtl/operand_store.sv
rtl/neural_rx_top.sv
verification/neural_rx_assert.sv
verification/tb_neural_rx.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_neural_rx -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_neural_rx)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1
